// ==== logic/videoPkg.sv ====
`default_nettype none

// Pixel side of the mixer: line buffer, sprite and palette types
package videoPkg;

	localparam int lineWidth = 320;		// Visible pixels per scanline
	localparam int xBits = 9;			// Enough for 0..511

	// Last valid x, anything above is off screen
	localparam logic [xBits-1:0] lastX = xBits'(lineWidth - 1);

	typedef logic [3:0] colorT;			// Zero is transparent
	typedef logic [7:0] paletteT;		// Sprite palette number
	typedef logic [3:0] fixPaletteT;	// Fix layer palette number
	typedef logic [11:0] paletteAddrT;	// Palette RAM address

	// Palette RAM address used while blanking
	localparam paletteAddrT blankAddr = '0;

	// One line buffer entry, lines up with a palette address
	typedef struct packed
	{
		paletteT palette;
		colorT color;
	} lbEntryT;

	// Sprite renderer output, one per pixel clock
	typedef struct packed
	{
		logic load;						// Start a run at x
		logic [xBits-1:0] x;			// Run start position
		logic write;					// Store one pixel, then x+1
		colorT color;
		paletteT palette;				// Only valid with load
	} spritePixelT;

	// Who owns the palette address this cycle
	typedef enum logic [1:0]
	{
		sourceCpu,
		sourceBlank,
		sourceFix,
		sourceSprite
	} paletteSourceE;

endpackage

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

// CPU side: bus request, palette window, watchdog
package cpuPkg;

	localparam int addrBits = 24;

	// 68k style request, held stable while req is high
	typedef struct packed
	{
		logic req;
		logic write;
		logic [addrBits-1:0] addr;
	} cpuReqT;

	// Palette RAM window in CPU space
	localparam logic [addrBits-1:0] paletteBase = 24'h400000;
	localparam logic [addrBits-1:0] paletteLimit = 24'h7FFFFF;

	localparam logic [addrBits-1:0] kickAddr = 24'h300001;	// Watchdog kick

	localparam int watchdogLimit = 1024;	// Pixel clocks without a kick
	localparam int resetPulse = 16;			// systemReset length

	localparam int wdCountBits = $clog2(watchdogLimit);
	localparam int pulseBits = $clog2(resetPulse);

	// Terminal counts
	localparam logic [wdCountBits-1:0] wdCountLast = wdCountBits'(watchdogLimit - 1);
	localparam logic [pulseBits-1:0] pulseLast = pulseBits'(resetPulse - 1);

	typedef enum logic
	{
		wdCounting,
		wdResetting
	} wdStateE;

endpackage

`default_nettype wire

// ==== logic/lineBuffer.sv ====
`default_nettype none

// One scanline of sprite pixels
// Write side skips transparent pixels, read side clears behind itself
module lineBuffer
(
	input wire logic S1H1,
	input wire logic nS1H1,

	// Fill side
	input wire logic writeEnable,
	input wire logic [videoPkg::xBits-1:0] writeX,
	input wire videoPkg::lbEntryT writeData,

	// Readout side
	input wire logic readEnable,
	input wire logic [videoPkg::xBits-1:0] readX,
	output videoPkg::lbEntryT readData
);

	videoPkg::lbEntryT entries [videoPkg::lineWidth];

	logic writeHit;		// Opaque pixel landing on screen
	logic readHit;		// Read inside the line

	// Colour zero leaves whatever is already there
	assign writeHit = writeEnable
		&& (writeData.color != '0)
		&& (writeX <= videoPkg::lastX);

	assign readHit = readEnable && (readX <= videoPkg::lastX);

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			// Whole line starts transparent
			for (int i = 0; i < videoPkg::lineWidth; i++)
			begin
				entries[i] <= '0;
			end
			readData <= '0;
		end
		else
		begin
			if (readHit)
			begin
				readData <= entries[readX];		// One cycle read
				entries[readX] <= '0;			// Clear behind the beam
			end
			else if (readEnable)
			begin
				readData <= '0;					// Off screen reads as empty
			end

			// Write last, so it wins on a same-address clash
			if (writeHit)
			begin
				entries[writeX] <= writeData;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/lineBufferBank.sv ====
`default_nettype none

// Ping-pong pair of line buffers
// One fills for the next line while the other is shown and cleared
module lineBufferBank
(
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire videoPkg::spritePixelT spritePixel,
	input wire logic lineStart,		// Swap strobe
	input wire logic pixelEnable,	// One displayed pixel
	output videoPkg::lbEntryT spriteEntry
);

	logic writeSel;									// Buffer being filled
	logic readSelQ;									// Buffer behind readData, one cycle late
	logic [videoPkg::xBits-1:0] writeX;				// Next write position
	logic [videoPkg::xBits-1:0] writeXNow;
	logic [videoPkg::xBits-1:0] readX;
	videoPkg::paletteT spritePalette;				// Held across the run
	videoPkg::lbEntryT writeEntry;
	videoPkg::lbEntryT readData [2];
	logic [1:0] writeEnable;
	logic [1:0] readEnable;

	// A load may come with the first pixel of its run
	assign writeXNow = spritePixel.load ? spritePixel.x : writeX;
	assign writeEntry.palette = spritePixel.load ? spritePixel.palette : spritePalette;
	assign writeEntry.color = spritePixel.color;

	assign writeEnable[0] = spritePixel.write && !writeSel;
	assign writeEnable[1] = spritePixel.write && writeSel;
	assign readEnable[0] = pixelEnable && writeSel;		// Read the other one
	assign readEnable[1] = pixelEnable && !writeSel;

	assign spriteEntry = readData[readSelQ];

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			writeSel <= 1'b0;			// Fill buffer 0 first
			readSelQ <= 1'b1;
			writeX <= '0;
			readX <= '0;
		end
		else
		begin
			if (lineStart)
				writeSel <= !writeSel;	// Takes effect next cycle
			readSelQ <= !writeSel;

			// Transparent pixels still step x
			if (spritePixel.write)
				writeX <= writeXNow + 1'b1;
			else if (spritePixel.load)
				writeX <= spritePixel.x;

			if (lineStart)
				readX <= '0;
			else if (pixelEnable)
				readX <= readX + 1'b1;
		end
	end

	// Palette shows up once per run
	always_ff @(posedge S1H1)
	begin
		if (spritePixel.load)
			spritePalette <= spritePixel.palette;
	end

	lineBuffer u_lineBuffer0
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.writeEnable(writeEnable[0]),
		.writeX(writeXNow),
		.writeData(writeEntry),
		.readEnable(readEnable[0]),
		.readX(readX),
		.readData(readData[0])
	);

	lineBuffer u_lineBuffer1
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.writeEnable(writeEnable[1]),
		.writeX(writeXNow),
		.writeData(writeEntry),
		.readEnable(readEnable[1]),
		.readX(readX),
		.readData(readData[1])
	);

endmodule

`default_nettype wire

// ==== logic/fixLayer.sv ====
`default_nettype none

// Fix (text) layer with two 4-bit pixels per byte
// Low nibble on the load cycle, high nibble on the one after
module fixLayer
(
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic fixLoad,
	input wire logic [7:0] fixByte,
	input wire videoPkg::fixPaletteT fixPalette,
	output videoPkg::paletteAddrT fixAddr,	// Registered palette and colour
	output logic fixOpaque
);

	logic [7:0] fixData;				// Latched pixel pair
	videoPkg::fixPaletteT fixPal;		// Latched palette
	logic nibbleHigh;					// Next pixel from the upper half
	videoPkg::colorT pixelNow;
	videoPkg::fixPaletteT palNow;

	// Load cycle bypasses the latches
	assign pixelNow = fixLoad ? fixByte[3:0] : (nibbleHigh ? fixData[7:4] : fixData[3:0]);
	assign palNow = fixLoad ? fixPalette : fixPal;

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			fixData <= '0;
			nibbleHigh <= 1'b0;
			fixOpaque <= 1'b0;
		end
		else
		begin
			if (fixLoad)
				fixData <= fixByte;
			nibbleHigh <= fixLoad ? 1'b1 : !nibbleHigh;	// Flip every pixel
			fixOpaque <= pixelNow != '0;
		end
	end

	// Extra stage lines up with the line buffer read
	always_ff @(posedge S1H1)
	begin
		if (fixLoad)
			fixPal <= fixPalette;
		fixAddr <= {4'h0, palNow, pixelNow};	// Fix palettes sit at the bottom
	end

endmodule

`default_nettype wire

// ==== logic/paletteArbiter.sv ====
`default_nettype none

// Palette address mux
// Order: CPU, blank, opaque fix, sprite
module paletteArbiter
(
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire cpuPkg::cpuReqT cpuReq,
	output logic cpuAck,
	input wire logic blank,
	input wire logic pixelValid,				// Raw pixelEnable, delayed here
	input wire videoPkg::paletteAddrT fixAddr,
	input wire logic fixOpaque,
	input wire videoPkg::lbEntryT spriteEntry,
	output videoPkg::paletteAddrT paletteAddr,
	output logic paletteValid,
	output videoPkg::paletteSourceE paletteSource
);

	logic inRange;			// Address inside palette RAM
	logic ackNext;
	logic blankQ;			// Aligned with line buffer data
	logic pixelValidQ;
	videoPkg::paletteAddrT addrNext;
	videoPkg::paletteSourceE sourceNext;

	assign inRange = (cpuReq.addr >= cpuPkg::paletteBase)
		&& (cpuReq.addr <= cpuPkg::paletteLimit);

	// Ack tracks req one cycle late, never outside the window
	assign ackNext = cpuReq.req && inRange;

	always_comb
	begin
		if (ackNext)
		begin
			addrNext = cpuReq.addr[12:1];				// Word address
			sourceNext = videoPkg::sourceCpu;
		end
		else if (blankQ)
		begin
			addrNext = videoPkg::blankAddr;
			sourceNext = videoPkg::sourceBlank;
		end
		else if (fixOpaque)
		begin
			addrNext = fixAddr;
			sourceNext = videoPkg::sourceFix;
		end
		else
		begin
			addrNext = {spriteEntry.palette, spriteEntry.color};	// Empty gives 0
			sourceNext = videoPkg::sourceSprite;
		end
	end

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			cpuAck <= 1'b0;
			blankQ <= 1'b0;
			pixelValidQ <= 1'b0;
			paletteValid <= 1'b0;
			paletteSource <= videoPkg::sourceBlank;
		end
		else
		begin
			cpuAck <= ackNext;			// Same edge as the CPU address
			blankQ <= blank;
			pixelValidQ <= pixelValid;
			paletteValid <= pixelValidQ;	// Two cycles after pixelEnable
			paletteSource <= sourceNext;
		end
	end

	always_ff @(posedge S1H1)
	begin
		paletteAddr <= addrNext;
	end

endmodule

`default_nettype wire

// ==== logic/watchdog.sv ====
`default_nettype none

// CPU watchdog on the pixel clock
// Kick is a write to kickAddr, expiry gives a fixed reset pulse
module watchdog
(
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire cpuPkg::cpuReqT cpuReq,
	output logic systemReset
);

	cpuPkg::wdStateE state;
	logic reqQ;									// For the req edge
	logic kick;
	logic [cpuPkg::wdCountBits-1:0] count;		// Clocks since last kick
	logic [cpuPkg::pulseBits-1:0] pulseCount;

	// One kick per bus cycle, held req does not count twice
	assign kick = cpuReq.req && !reqQ
		&& cpuReq.write
		&& (cpuReq.addr == cpuPkg::kickAddr);

	assign systemReset = state == cpuPkg::wdResetting;

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			state <= cpuPkg::wdCounting;
			reqQ <= 1'b0;
			count <= '0;
			pulseCount <= '0;
		end
		else
		begin
			reqQ <= cpuReq.req;
			case (state)
				cpuPkg::wdCounting:
				begin
					if (kick)
						count <= '0;
					else if (count == cpuPkg::wdCountLast)
					begin
						state <= cpuPkg::wdResetting;	// Expired
						pulseCount <= '0;
					end
					else
						count <= count + 1'b1;
				end
				cpuPkg::wdResetting:
				begin
					// Kicks ignored while the pulse runs
					if (pulseCount == cpuPkg::pulseLast)
					begin
						state <= cpuPkg::wdCounting;
						count <= '0;					// Fresh timeout
					end
					else
						pulseCount <= pulseCount + 1'b1;
				end
				default:
					state <= cpuPkg::wdCounting;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/videoMixer.sv ====
`default_nettype none

// Pixel mixer top: sprite line buffers, fix layer, palette mux, watchdog
module videoMixer
(
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire videoPkg::spritePixelT spritePixel,
	input wire logic lineStart,
	input wire logic pixelEnable,
	input wire logic blank,
	input wire logic fixLoad,
	input wire logic [7:0] fixByte,
	input wire videoPkg::fixPaletteT fixPalette,
	input wire cpuPkg::cpuReqT cpuReq,
	output logic cpuAck,
	output videoPkg::paletteAddrT paletteAddr,
	output logic paletteValid,
	output videoPkg::paletteSourceE paletteSource,
	output logic systemReset
);

	videoPkg::lbEntryT spriteEntry;		// One cycle after pixelEnable
	videoPkg::paletteAddrT fixAddr;
	logic fixOpaque;

	lineBufferBank u_bank
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.spritePixel(spritePixel),
		.lineStart(lineStart),
		.pixelEnable(pixelEnable),
		.spriteEntry(spriteEntry)
	);

	fixLayer u_fixLayer
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.fixLoad(fixLoad),
		.fixByte(fixByte),
		.fixPalette(fixPalette),
		.fixAddr(fixAddr),
		.fixOpaque(fixOpaque)
	);

	// Arbiter delays pixelEnable and blank to meet the buffer data
	paletteArbiter u_arbiter
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.cpuReq(cpuReq),
		.cpuAck(cpuAck),
		.blank(blank),
		.pixelValid(pixelEnable),
		.fixAddr(fixAddr),
		.fixOpaque(fixOpaque),
		.spriteEntry(spriteEntry),
		.paletteAddr(paletteAddr),
		.paletteValid(paletteValid),
		.paletteSource(paletteSource)
	);

	watchdog u_watchdog
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.cpuReq(cpuReq),
		.systemReset(systemReset)
	);

endmodule

`default_nettype wire

// ==== test/tbVideoMixer.sv ====
`default_nettype none

// Testbench for the pixel mixer top level
module tbVideoMixer;

	localparam int lineCount = 5;
	localparam int runBStart = 160;		// Pixel slot where the second sprite run begins

	// One scanline of stimulus and its CPU access
	typedef struct packed
	{
		logic [8:0] xA;
		logic [7:0] palA;
		logic [7:0] lenA;
		logic [8:0] xB;
		logic [7:0] palB;
		logic [7:0] lenB;
		logic [7:0] fixPattern;			// Shown where pixel bit 3 is set
		logic [3:0] fixPal;
		logic [8:0] blankLo;
		logic [8:0] blankHi;			// Exclusive
		logic cpuOn;
		logic [23:0] cpuAddr;
		logic cpuExpAck;
	} lineT;

	logic S1H1 = 1'b0;
	logic nS1H1;
	videoPkg::spritePixelT spritePixel;
	logic lineStart;
	logic pixelEnable;
	logic blank;
	logic fixLoad;
	logic [7:0] fixByte;
	videoPkg::fixPaletteT fixPalette;
	cpuPkg::cpuReqT cpuReq;
	logic cpuAck;
	videoPkg::paletteAddrT paletteAddr;
	logic paletteValid;
	videoPkg::paletteSourceE paletteSource;
	logic systemReset;

	lineT lines [lineCount];
	videoPkg::lbEntryT model [2][videoPkg::lineWidth];	// Reference copy of both buffers
	logic modelSel;										// Buffer being filled
	logic [31:0] lfsr;

	// Pixels in flight with the oldest first
	videoPkg::paletteAddrT expAddr [$];
	videoPkg::paletteSourceE expSrc [$];
	string expName [$];

	always #4 S1H1 = !S1H1;

	videoMixer u_videoMixer
	(
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.spritePixel(spritePixel),
		.lineStart(lineStart),
		.pixelEnable(pixelEnable),
		.blank(blank),
		.fixLoad(fixLoad),
		.fixByte(fixByte),
		.fixPalette(fixPalette),
		.cpuReq(cpuReq),
		.cpuAck(cpuAck),
		.paletteAddr(paletteAddr),
		.paletteValid(paletteValid),
		.paletteSource(paletteSource),
		.systemReset(systemReset)
	);

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;		// Galois taps
		return state >> 1;
	endfunction

	// Four LFSR bits per colour so zero comes out now and then
	function automatic videoPkg::colorT randomColor();
		videoPkg::colorT color;
		color = '0;
		for (int i = 0; i < 4; i++)
		begin
			color = {color[2:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return color;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error %s expected %0h actual %0h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic nextCycle();
		@(posedge S1H1);
		#1;		// Inputs change just after the edge
	endtask

	// Output side sampled mid-cycle
	always @(negedge S1H1)
	begin
		if (!nS1H1 && paletteValid)
		begin
			if (expAddr.size() == 0)
				reportFailure("paletteValid went high with no pixel pending");
			else
			begin
				checkValue({expName[0], " addr"}, expAddr[0], paletteAddr);
				checkValue({expName[0], " source"}, expSrc[0], paletteSource);
				void'(expAddr.pop_front());
				void'(expSrc.pop_front());
				void'(expName.pop_front());
			end
		end
	end

	// One sprite pixel into the buffer being filled and into the model
	task automatic writeSprite(input logic first, input logic [8:0] x,
		input videoPkg::paletteT pal, input int offset);
		videoPkg::colorT color;
		color = randomColor();
		spritePixel.load = first;
		spritePixel.x = x;
		spritePixel.write = 1'b1;
		spritePixel.color = color;
		spritePixel.palette = first ? pal : 8'h00;		// Palette only with the load
		if (color != '0)
			model[modelSel][x + offset] = {pal, color};	// Transparent leaves old data
	endtask

	task automatic cpuAccess(input logic [23:0] addr, input logic expectAck);
		string name;
		name = $sformatf("cpu %06h", addr);
		cpuReq.req = 1'b1;
		cpuReq.write = 1'b0;
		cpuReq.addr = addr;
		if (expectAck)
		begin
			for (int t = 0; !cpuAck; t++)
			begin
				if (t == 8)
					reportFailure("cpuAck never rose for a palette address");
				nextCycle();
			end
			// Word address held while req stays up
			for (int i = 0; i < 4; i++)
			begin
				checkValue({name, " addr"}, addr[12:1], paletteAddr);
				checkValue({name, " source"}, videoPkg::sourceCpu, paletteSource);
				nextCycle();
			end
			cpuReq.req = 1'b0;
			for (int t = 0; cpuAck; t++)
			begin
				if (t == 8)
					reportFailure("cpuAck stayed high after req dropped");
				nextCycle();
			end
		end
		else
		begin
			// Bounded wait where no ack is the right answer
			for (int i = 0; i < 16; i++)
			begin
				checkValue({name, " ack"}, 0, cpuAck);
				nextCycle();
			end
		end
		cpuReq = '0;
		nextCycle();
	endtask

	task automatic runLine(input int n);
		lineT ln;
		logic [7:0] byteNow;
		videoPkg::colorT nibble;
		videoPkg::lbEntryT entry;
		logic readSel;
		ln = lines[n];
		lineStart = 1'b1;			// Swap on its own cycle
		nextCycle();
		lineStart = 1'b0;
		modelSel = !modelSel;
		readSel = !modelSel;
		for (int c = 0; c < videoPkg::lineWidth; c++)
		begin
			if (c % 64 == 0 && c != 0)
			begin
				pixelEnable = 1'b0;		// Idle slot before an even pixel
				fixLoad = 1'b0;
				blank = 1'b0;
				spritePixel = '0;
				nextCycle();
			end
			spritePixel = '0;
			if (c < ln.lenA)
				writeSprite(c == 0, ln.xA, ln.palA, c);
			else if (c >= runBStart && c < runBStart + ln.lenB)
				writeSprite(c == runBStart, ln.xB, ln.palB, c - runBStart);

			byteNow = c[3] ? ln.fixPattern : 8'h00;
			nibble = c[0] ? byteNow[7:4] : byteNow[3:0];	// Low nibble first
			pixelEnable = 1'b1;
			blank = (c >= ln.blankLo) && (c < ln.blankHi);
			fixLoad = !c[0];
			fixByte = c[0] ? ~byteNow : byteNow;			// Junk between loads
			fixPalette = c[0] ? ~ln.fixPal : ln.fixPal;

			entry = model[readSel][c];
			model[readSel][c] = '0;		// Cleared by the read

			if (blank)
			begin
				expAddr.push_back('0);
				expSrc.push_back(videoPkg::sourceBlank);
			end
			else if (nibble != '0)
			begin
				expAddr.push_back({4'h0, ln.fixPal, nibble});
				expSrc.push_back(videoPkg::sourceFix);
			end
			else
			begin
				expAddr.push_back({entry.palette, entry.color});
				expSrc.push_back(videoPkg::sourceSprite);
			end
			expName.push_back($sformatf("line %0d pixel %0d", n, c));
			nextCycle();
		end
		pixelEnable = 1'b0;
		fixLoad = 1'b0;
		blank = 1'b0;
		spritePixel = '0;
		for (int t = 0; expAddr.size() != 0; t++)
		begin
			if (t == 8)
				reportFailure("paletteValid missing for pixels of the last line");
			nextCycle();
		end
		if (ln.cpuOn)
			cpuAccess(ln.cpuAddr, ln.cpuExpAck);
	endtask

	task automatic watchdogTest();
		int high;
		// Let any pulse in progress finish first
		for (int t = 0; systemReset; t++)
		begin
			if (t == 4 * cpuPkg::resetPulse)
				reportFailure("systemReset stuck high before the watchdog test");
			nextCycle();
		end
		for (int t = 0; !systemReset; t++)
		begin
			if (t == 2 * cpuPkg::watchdogLimit + 64)
				reportFailure("watchdog never expired without kicks");
			nextCycle();
		end
		high = 0;
		for (int t = 0; systemReset; t++)
		begin
			if (t == 4 * cpuPkg::resetPulse)
				reportFailure("systemReset pulse never ended");
			high++;
			nextCycle();
		end
		checkValue("watchdog pulse length", cpuPkg::resetPulse, high);

		// Kicks every 300 clocks for three limits
		for (int i = 0; i < 3 * cpuPkg::watchdogLimit; i++)
		begin
			cpuReq = '0;
			if (i % 300 == 0)
			begin
				cpuReq.req = 1'b1;
				cpuReq.write = 1'b1;
				cpuReq.addr = cpuPkg::kickAddr;
			end
			checkValue("watchdog with kicks", 0, systemReset);
			nextCycle();
		end
		cpuReq = '0;
	endtask

	initial
	begin
		lfsr = 32'hf9cc;
		modelSel = 1'b0;
		nS1H1 = 1'b1;
		spritePixel = '0;
		lineStart = 1'b0;
		pixelEnable = 1'b0;
		blank = 1'b0;
		fixLoad = 1'b0;
		fixByte = '0;
		fixPalette = '0;
		cpuReq = '0;
		for (int b = 0; b < 2; b++)
			for (int x = 0; x < videoPkg::lineWidth; x++)
				model[b][x] = '0;

		// Sprite runs, fix pattern, blank window, CPU access
		lines[0] = '{xA: 9'd10, palA: 8'h12, lenA: 8'd20, xB: 9'd200, palB: 8'h34, lenB: 8'd30,
			fixPattern: 8'h00, fixPal: 4'h0, blankLo: 9'd0, blankHi: 9'd0,
			cpuOn: 1'b1, cpuAddr: 24'h400010, cpuExpAck: 1'b1};
		lines[1] = '{xA: 9'd5, palA: 8'h56, lenA: 8'd40, xB: 9'd30, palB: 8'h78, lenB: 8'd10,
			fixPattern: 8'h3A, fixPal: 4'h5, blankLo: 9'd0, blankHi: 9'd0,
			cpuOn: 1'b1, cpuAddr: 24'h200000, cpuExpAck: 1'b0};
		lines[2] = '{xA: 9'd100, palA: 8'h9A, lenA: 8'd60, xB: 9'd280, palB: 8'hBC, lenB: 8'd39,
			fixPattern: 8'h70, fixPal: 4'h9, blankLo: 9'd0, blankHi: 9'd16,
			cpuOn: 1'b1, cpuAddr: 24'h7FFFFE, cpuExpAck: 1'b1};
		lines[3] = '{xA: 9'd0, palA: 8'hDE, lenA: 8'd64, xB: 9'd150, palB: 8'hF1, lenB: 8'd20,
			fixPattern: 8'h0C, fixPal: 4'h3, blankLo: 9'd300, blankHi: 9'd320,
			cpuOn: 1'b1, cpuAddr: 24'h800000, cpuExpAck: 1'b0};
		lines[4] = '{xA: 9'd0, palA: 8'h00, lenA: 8'd0, xB: 9'd0, palB: 8'h00, lenB: 8'd0,
			fixPattern: 8'h5F, fixPal: 4'h2, blankLo: 9'd100, blankHi: 9'd140,
			cpuOn: 1'b0, cpuAddr: 24'h000000, cpuExpAck: 1'b0};	// Flushes line 3

		repeat (4) @(posedge S1H1);
		#1;
		nS1H1 = 1'b0;
		checkValue("reset cpuAck", 0, cpuAck);
		checkValue("reset paletteValid", 0, paletteValid);
		checkValue("reset systemReset", 0, systemReset);

		for (int n = 0; n < lineCount; n++)
			runLine(n);
		watchdogTest();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/videoPkg.sv
logic/cpuPkg.sv
logic/lineBuffer.sv
logic/lineBufferBank.sv
logic/fixLayer.sv
logic/paletteArbiter.sv
logic/watchdog.sv
logic/videoMixer.sv
test/tbVideoMixer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mixer testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tbVideoMixer -f compile.f -o simVideoMixer \
	&& ./obj_dir/simVideoMixer > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
